/* list.f */
common/exu_pkg.sv
logic/alu.sv
logic/bypass_table.sv
logic/branch_unit.sv
exu/ex_stage_reg.sv
exu/exu_ctrl.sv
exu/exu_top.sv
verif/tb_exu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_exu.sv */
module tb_exu;

    localparam int CLK_PERIOD  = 4;
    localparam int N_ALU       = 300;
    localparam int N_FWD       = 80;
    localparam int N_BRANCH    = 10;                // Per compare op.
    localparam int N_BP        = 200;
    localparam int TEST_CYCLES = 8 * (N_ALU + N_FWD + 8 * N_BRANCH * 4 + N_BP) + 400;

    logic clk;
    logic rst;
    logic in_valid;
    logic [31:0] in_pc;
    logic [31:0] in_imm;
    logic [3:0] in_rd;
    logic [3:0] in_rs1;
    logic [3:0] in_rs2;
    logic [31:0] in_src1_reg;
    logic [31:0] in_src2_reg;
    exu_pkg::alu_op_e in_alu_op;
    exu_pkg::cmp_op_e in_cmp_op;
    logic in_src1_is_pc;
    logic in_src2_is_imm;
    logic in_is_jalr;
    logic in_is_load;
    logic in_gpr_we;
    logic in_ready;
    logic load_done;
    logic [31:0] load_data;
    logic ex_valid;
    logic [31:0] ex_pc;
    logic [3:0] ex_rd;
    logic [31:0] ex_result;
    logic [31:0] ex_store_data;
    logic ex_is_load;
    logic ex_gpr_we;
    logic lsu_ready;
    logic redirect_valid;
    logic [31:0] redirect_pc;
    logic redirect_ack;

    integer seed;
    int errors;
    int err_mark;
    int tests_done;
    bit bp_random;                              // Random lsu_ready while set.
    logic [3:0] hist_rd[$];                     // Every register write, oldest first.
    logic [31:0] hist_val[$];
    bit hist_pend[$];
    logic [101:0] exp_q[$];                     // {pc, rd, result, store_data, is_load, gpr_we}.
    logic [101:0] exp_e;
    logic [101:0] out_bus;
    logic [101:0] last_bus;
    logic last_valid;
    logic last_lsu;
    bit exp_redir;
    bit exp_out;                                // Accepted and not squashed.
    logic [31:0] exp_tgt;

    exu_top #(.BYPASS_DEPTH(4)) DUT (.*);

    assign out_bus = {ex_pc, ex_rd, ex_result, ex_store_data, ex_is_load, ex_gpr_we};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic mismatch(string name, logic [101:0] exp, logic [101:0] act);
        $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic failure(string what);
        $display("ERROR time=%0t %s", $time, what);
        errors++;
    endtask

    // Payload leaves when the LSU takes it.
    always @(posedge clk) begin
        if (!rst && ex_valid && lsu_ready) begin
            assert (exp_q.size() != 0)
                else failure("ex_valid high with no instruction outstanding");
            if (exp_q.size() != 0) begin
                exp_e = exp_q.pop_front();
                assert (ex_pc == exp_e[101:70]) else mismatch("ex_pc", exp_e[101:70], ex_pc);
                assert (ex_result == exp_e[65:34])
                    else mismatch("ex_result", exp_e[65:34], ex_result);
                assert (ex_store_data == exp_e[33:2])
                    else mismatch("ex_store_data", exp_e[33:2], ex_store_data);
                assert ({ex_rd, ex_is_load, ex_gpr_we} == {exp_e[69:66], exp_e[1:0]})
                    else mismatch("ex_rd/ex_is_load/ex_gpr_we", {exp_e[69:66], exp_e[1:0]},
                                  {ex_rd, ex_is_load, ex_gpr_we});
            end
        end
        if (!rst && !last_lsu) begin
            assert (ex_valid == last_valid) else
                mismatch("ex_valid under back-pressure", 102'(last_valid), 102'(ex_valid));
            assert (out_bus == last_bus) else
                mismatch("ex outputs under back-pressure", last_bus, out_bus);
        end
        last_bus = out_bus;
        last_valid = ex_valid;
        last_lsu = lsu_ready;
    end

    assert property (@(posedge clk) disable iff (rst) !lsu_ready |-> !in_ready)
        else failure("in_ready high while lsu_ready is low");
    assert property (@(posedge clk) disable iff (rst)
        (redirect_valid && !redirect_ack) |=> redirect_valid)
        else failure("redirect_valid dropped without redirect_ack");

    function automatic logic [31:0] alu_model(exu_pkg::alu_op_e op, logic [31:0] a,
                                              logic [31:0] b);
        case (op)
            exu_pkg::alu_add:  return a + b;
            exu_pkg::alu_sub:  return a - b;
            exu_pkg::alu_sll:  return a << b[4:0];
            exu_pkg::alu_slt:  return {31'd0, $signed(a) < $signed(b)};
            exu_pkg::alu_sltu: return {31'd0, a < b};
            exu_pkg::alu_xor:  return a ^ b;
            exu_pkg::alu_srl:  return a >> b[4:0];
            exu_pkg::alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            exu_pkg::alu_or:   return a | b;
            exu_pkg::alu_and:  return a & b;
            default:           return b;    // lui passes the immediate.
        endcase
    endfunction

    function automatic bit cond_model(exu_pkg::cmp_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            exu_pkg::cmp_always: return 1'b1;
            exu_pkg::cmp_eq:     return a == b;
            exu_pkg::cmp_ne:     return a != b;
            exu_pkg::cmp_lt:     return $signed(a) < $signed(b);
            exu_pkg::cmp_ge:     return $signed(a) >= $signed(b);
            exu_pkg::cmp_ltu:    return a < b;
            exu_pkg::cmp_geu:    return a >= b;
            default:             return 1'b0;
        endcase
    endfunction

    // Newest value of a register; x0 and unwritten ones read the register file.
    function automatic logic [31:0] operand(logic [3:0] r, logic [31:0] reg_val);
        logic [31:0] v;
        v = reg_val;
        for (int i = 0; i < hist_rd.size(); i++)
            if (r != 4'd0 && hist_rd[i] == r) v = hist_val[i];
        return v;
    endfunction

    // Register file view, which lags the last four writes.
    function automatic logic [31:0] stale_val(logic [3:0] r);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < hist_rd.size() - 4; i++)
            if (hist_rd[i] == r) v = hist_val[i];
        return v;
    endfunction

    function automatic bit waits_on_load(logic [3:0] r);
        bit p;
        p = 1'b0;
        for (int i = 0; i < hist_rd.size(); i++)
            if (r != 4'd0 && hist_rd[i] == r) p = hist_pend[i];
        return p;
    endfunction

    task automatic drive_regs();
        in_src1_reg = (in_rs1 == 4'd0) ? 32'($random(seed)) : stale_val(in_rs1);
        in_src2_reg = (in_rs2 == 4'd0) ? 32'($random(seed)) : stale_val(in_rs2);
    endtask

    task automatic rand_instr(logic [3:0] reg_mask);
        in_valid       = 1'b1;
        in_pc          = 32'($random(seed)) & ~32'd3;
        in_imm         = 32'($random(seed));
        in_rd          = 4'($random(seed)) & reg_mask;
        in_rs1         = 4'($random(seed)) & reg_mask;
        in_rs2         = 4'($random(seed)) & reg_mask;
        in_alu_op      = exu_pkg::alu_op_e'(4'({$random(seed)} % 11));
        in_cmp_op      = exu_pkg::cmp_none;
        in_src1_is_pc  = 1'($random(seed));
        in_src2_is_imm = 1'($random(seed));
        in_is_jalr     = 1'b0;
        in_is_load     = 1'b0;
        in_gpr_we      = 1'($random(seed)) | 1'($random(seed));
        drive_regs();
    endtask

    // Expected results at the accepting edge, from the model state.
    task automatic record();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] res;
        logic [31:0] wb;
        v1 = operand(in_rs1, in_src1_reg);
        v2 = operand(in_rs2, in_src2_reg);
        res = alu_model(in_alu_op, in_src1_is_pc ? in_pc : v1, in_src2_is_imm ? in_imm : v2);
        exp_redir = redirect_valid;             // Squashed while a redirect is pending.
        exp_out = !redirect_valid;
        if (!redirect_valid) begin
            wb = (in_cmp_op == exu_pkg::cmp_always) ? in_pc + 32'd4 : res;
            exp_q.push_back({in_pc, in_rd, wb, v2, in_is_load, in_gpr_we});
            exp_tgt = in_is_jalr ? {res[31:1], 1'b0} : res;
            exp_redir = cond_model(in_cmp_op, v1, v2) && (exp_tgt != in_pc + 32'd4);
            if (in_gpr_we && in_rd != 4'd0) begin
                hist_rd.push_back(in_rd);
                hist_val.push_back(wb);
                hist_pend.push_back(in_is_load);
            end
        end
    endtask

    task automatic issue();
        bit stall;
        bit accepted;
        int waited;
        accepted = 1'b0;
        waited = 0;
        while (!accepted && waited <= 60) begin
            @(posedge clk);
            stall = waits_on_load(in_rs1) || waits_on_load(in_rs2);
            assert (!(stall && in_ready))
                else failure("in_ready high while a source waits on a load");
            assert (!(lsu_ready && !stall && !in_ready))
                else failure("in_ready low without a cause");
            if (in_ready) begin
                record();
                accepted = 1'b1;
            end
            #1;
            if (bp_random) lsu_ready = 1'($random(seed));
            waited++;
        end
        in_valid = 1'b0;
        if (!accepted) begin
            failure("instruction was never accepted");
        end else begin
            assert (ex_valid == exp_out)
                else mismatch("ex_valid", 102'(exp_out), 102'(ex_valid));
            assert (redirect_valid == exp_redir)
                else mismatch("redirect_valid", 102'(exp_redir), 102'(redirect_valid));
            if (exp_redir) begin
                assert (redirect_pc == exp_tgt)
                    else mismatch("redirect_pc", exp_tgt, redirect_pc);
            end
        end
    endtask

    task automatic pulse_load_done(logic [31:0] data);
        bit filled;
        filled = 1'b0;
        load_done = 1'b1;
        load_data = data;
        @(posedge clk);
        for (int i = 0; i < hist_rd.size(); i++) begin
            if (!filled && hist_pend[i]) begin
                hist_val[i] = data;
                hist_pend[i] = 1'b0;
                filled = 1'b1;
            end
        end
        #1 load_done = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        bp_random = 1'b0;
        lsu_ready = 1'b1;
        while ((exp_q.size() != 0 || ex_valid) && n < 20) begin
            @(posedge clk);
            #1 n++;
        end
        assert (exp_q.size() == 0) else failure("outputs did not drain, instructions lost");
    endtask

    task automatic end_test(string name);
        drain();
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
        tests_done++;
    endtask

    initial begin
        #(2 * CLK_PERIOD * TEST_CYCLES + 1000);
        $display("ERROR watchdog expired, the run did not complete");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed = 32'hff0c;
        errors = 0;
        err_mark = 0;
        tests_done = 0;
        bp_random = 1'b0;
        last_lsu = 1'b1;
        rst = 1'b1;
        lsu_ready = 1'b1;
        load_done = 1'b0;
        load_data = '0;
        redirect_ack = 1'b0;
        rand_instr(4'hf);
        in_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        assert (!ex_valid && !redirect_valid) else failure("outputs not cleared by reset");

        for (int i = 0; i < N_ALU; i++) begin
            rand_instr(4'hf);
            if (i < 11) in_alu_op = exu_pkg::alu_op_e'(4'(i));
            issue();
        end
        end_test("reset_and_alu");

        for (int i = 0; i < N_FWD; i++) begin
            rand_instr(4'h7);                   // Few registers, many dependencies.
            in_gpr_we = 1'b1;
            issue();
        end
        end_test("forwarding");

        // Loads read only x0..x3, so they never wait on each other.
        for (int k = 0; k < 4; k++) begin
            rand_instr(4'h3);
            in_rd = 4'd5;
            in_is_load = 1'b1;
            in_gpr_we = 1'b1;
            issue();
            rand_instr(4'h3);
            in_rs1 = 4'd5;
            in_rs2 = 4'(6 + k % 2);
            in_rd = 4'd0;
            drive_regs();
            in_valid = 1'b1;
            repeat (3) begin
                @(posedge clk);
                assert (!in_ready) else failure("in_ready high under a load hazard");
                #1;
            end
            pulse_load_done(32'($random(seed)));
            issue();
            for (int j = 6; j < 8; j++) begin
                rand_instr(4'h3);
                in_rd = 4'(j);
                in_is_load = 1'b1;
                in_gpr_we = 1'b1;
                issue();
            end
            pulse_load_done(32'($random(seed)));
            pulse_load_done(32'($random(seed)));
        end
        end_test("load_hazard");

        for (int c = 0; c < 8; c++) begin
            repeat (N_BRANCH) begin
                rand_instr(4'h7);
                in_cmp_op = exu_pkg::cmp_op_e'(3'(c));
                in_alu_op = exu_pkg::alu_add;
                in_src2_is_imm = 1'b1;
                in_imm = $random(seed) & 1 ? 32'd4 : 32'($random(seed)) & ~32'd1;
                in_gpr_we = (c == 1);
                in_src1_is_pc = (c != 1) || 1'($random(seed));
                in_is_jalr = !in_src1_is_pc;
                if (1'($random(seed))) in_rs2 = in_rs1;
                drive_regs();
                issue();
                if (redirect_valid) begin
                    repeat (2) begin
                        rand_instr(4'h7);
                        issue();
                    end
                    redirect_ack = 1'b1;
                    @(posedge clk);
                    #1 redirect_ack = 1'b0;
                    assert (!redirect_valid) else failure("redirect_valid stayed high after ack");
                end
            end
        end
        end_test("redirect_and_squash");

        bp_random = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            rand_instr(4'h7);
            issue();
        end
        end_test("back_pressure");

        $display("tests run: %0d, errors: %0d", tests_done, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* exu/exu_top.sv */
module exu_top #(
    parameter int BYPASS_DEPTH = exu_pkg::DEFAULT_BYPASS_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [exu_pkg::XLEN-1:0]   in_pc,
    input  logic [exu_pkg::XLEN-1:0]   in_imm,
    input  logic [exu_pkg::REG_AW-1:0] in_rd,
    input  logic [exu_pkg::REG_AW-1:0] in_rs1,
    input  logic [exu_pkg::REG_AW-1:0] in_rs2,
    input  logic [exu_pkg::XLEN-1:0]   in_src1_reg,
    input  logic [exu_pkg::XLEN-1:0]   in_src2_reg,
    input  exu_pkg::alu_op_e          in_alu_op,
    input  exu_pkg::cmp_op_e          in_cmp_op,
    input  logic                      in_src1_is_pc,
    input  logic                      in_src2_is_imm,
    input  logic                      in_is_jalr,
    input  logic                      in_is_load,
    input  logic                      in_gpr_we,
    output logic                      in_ready,
    input  logic                      load_done,
    input  logic [exu_pkg::XLEN-1:0]   load_data,
    output logic                      ex_valid,
    output logic [exu_pkg::XLEN-1:0]   ex_pc,
    output logic [exu_pkg::REG_AW-1:0] ex_rd,
    output logic [exu_pkg::XLEN-1:0]   ex_result,
    output logic [exu_pkg::XLEN-1:0]   ex_store_data,
    output logic                      ex_is_load,
    output logic                      ex_gpr_we,
    input  logic                      lsu_ready,
    output logic                      redirect_valid,
    output logic [exu_pkg::XLEN-1:0]   redirect_pc,
    input  logic                      redirect_ack
);

    logic                     accept;
    logic                     squash;
    logic                     advance;
    logic                     hazard;
    logic                     take_redirect;
    logic                     cmp_true;
    logic                     push;
    logic [exu_pkg::XLEN-1:0] src1;
    logic [exu_pkg::XLEN-1:0] src2;
    logic [exu_pkg::XLEN-1:0] target;
    logic [exu_pkg::XLEN-1:0] alu_result;
    logic [exu_pkg::XLEN-1:0] wb_value;

    assign push = accept && !squash && in_gpr_we;

    exu_ctrl u_ctrl (
        .clk(clk), .rst(rst), .in_valid(in_valid), .lsu_ready(lsu_ready),
        .hazard(hazard), .take_redirect(take_redirect), .target(target),
        .redirect_ack(redirect_ack), .in_ready(in_ready), .accept(accept),
        .squash(squash), .advance(advance), .ex_valid(ex_valid),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    bypass_table #(.BYPASS_DEPTH(BYPASS_DEPTH)) u_bypass (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_rs1(in_rs1), .in_rs2(in_rs2),
        .in_src1_reg(in_src1_reg), .in_src2_reg(in_src2_reg), .push(push),
        .push_rd(in_rd), .push_data(wb_value), .push_is_load(in_is_load),
        .load_done(load_done), .load_data(load_data),
        .src1(src1), .src2(src2), .hazard(hazard)
    );

    alu u_alu (
        .alu_op(in_alu_op), .cmp_op(in_cmp_op), .pc(in_pc), .imm(in_imm),
        .src1(src1), .src2(src2), .src1_is_pc(in_src1_is_pc),
        .src2_is_imm(in_src2_is_imm), .alu_result(alu_result), .cmp_true(cmp_true)
    );

    branch_unit u_branch (
        .pc(in_pc), .cmp_op(in_cmp_op), .is_jalr(in_is_jalr), .alu_result(alu_result),
        .cmp_true(cmp_true), .take_redirect(take_redirect), .target(target)
    );

    ex_stage_reg u_stage_reg (
        .clk(clk), .rst(rst), .advance(advance), .pc(in_pc), .rd(in_rd),
        .cmp_op(in_cmp_op), .alu_result(alu_result), .src2(src2),
        .is_load(in_is_load), .gpr_we(in_gpr_we), .ex_pc(ex_pc), .ex_rd(ex_rd),
        .ex_result(ex_result), .ex_store_data(ex_store_data),
        .ex_is_load(ex_is_load), .ex_gpr_we(ex_gpr_we), .wb_value(wb_value)
    );

endmodule

/* exu/exu_ctrl.sv */
module exu_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic                    lsu_ready,
    input  logic                    hazard,
    input  logic                    take_redirect,
    input  logic [exu_pkg::XLEN-1:0] target,
    input  logic                    redirect_ack,
    output logic                    in_ready,
    output logic                    accept,
    output logic                    squash,
    output logic                    advance,
    output logic                    ex_valid,
    output logic                    redirect_valid,
    output logic [exu_pkg::XLEN-1:0] redirect_pc
);

    logic set_redirect;

    assign in_ready = lsu_ready && !hazard;
    assign accept   = in_valid && in_ready;
    assign advance  = lsu_ready;            // Output register holds under back-pressure.

    // Wrong-path instructions are dropped until fetch acknowledges.
    assign squash = redirect_valid;

    assign set_redirect = accept && !squash && take_redirect;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (advance) begin
            ex_valid <= accept && !squash;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else if (redirect_valid) begin
            if (redirect_ack)
                redirect_valid <= 1'b0;
        end else if (set_redirect) begin
            redirect_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (set_redirect)
            redirect_pc <= target;          // Held for as long as the request is up.
    end

endmodule

/* exu/ex_stage_reg.sv */
module ex_stage_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      advance,
    input  logic [exu_pkg::XLEN-1:0]   pc,
    input  logic [exu_pkg::REG_AW-1:0] rd,
    input  exu_pkg::cmp_op_e          cmp_op,
    input  logic [exu_pkg::XLEN-1:0]   alu_result,
    input  logic [exu_pkg::XLEN-1:0]   src2,
    input  logic                      is_load,
    input  logic                      gpr_we,
    output logic [exu_pkg::XLEN-1:0]   ex_pc,
    output logic [exu_pkg::REG_AW-1:0] ex_rd,
    output logic [exu_pkg::XLEN-1:0]   ex_result,
    output logic [exu_pkg::XLEN-1:0]   ex_store_data,
    output logic                      ex_is_load,
    output logic                      ex_gpr_we,
    output logic [exu_pkg::XLEN-1:0]   wb_value
);

    // Jumps write the link address.
    assign wb_value = (cmp_op == exu_pkg::cmp_always) ? pc + 32'd4 : alu_result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_is_load <= 1'b0;
            ex_gpr_we  <= 1'b0;
        end else if (advance) begin
            ex_is_load <= is_load;
            ex_gpr_we  <= gpr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_pc         <= pc;
            ex_rd         <= rd;
            ex_result     <= wb_value;
            ex_store_data <= src2;          // Store data is rs2.
        end
    end

endmodule

/* logic/branch_unit.sv */
module branch_unit (
    input  logic [exu_pkg::XLEN-1:0] pc,
    input  exu_pkg::cmp_op_e        cmp_op,
    input  logic                    is_jalr,
    input  logic [exu_pkg::XLEN-1:0] alu_result,
    input  logic                    cmp_true,
    output logic                    take_redirect,
    output logic [exu_pkg::XLEN-1:0] target
);

    logic [exu_pkg::XLEN-1:0] seq_pc;
    logic                     is_ctrl;

    assign seq_pc  = pc + 32'd4;
    assign is_ctrl = (cmp_op != exu_pkg::cmp_none);

    // Jalr drops the low bit of rs1 + imm.
    assign target = is_jalr ? {alu_result[exu_pkg::XLEN-1:1], 1'b0} : alu_result;

    // A taken branch to the next pc needs no refetch.
    assign take_redirect = is_ctrl && cmp_true && (target != seq_pc);

endmodule

/* logic/bypass_table.sv */
module bypass_table #(
    parameter int BYPASS_DEPTH = exu_pkg::DEFAULT_BYPASS_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [exu_pkg::REG_AW-1:0] in_rs1,
    input  logic [exu_pkg::REG_AW-1:0] in_rs2,
    input  logic [exu_pkg::XLEN-1:0]   in_src1_reg,
    input  logic [exu_pkg::XLEN-1:0]   in_src2_reg,
    input  logic                      push,
    input  logic [exu_pkg::REG_AW-1:0] push_rd,
    input  logic [exu_pkg::XLEN-1:0]   push_data,
    input  logic                      push_is_load,
    input  logic                      load_done,
    input  logic [exu_pkg::XLEN-1:0]   load_data,
    output logic [exu_pkg::XLEN-1:0]   src1,
    output logic [exu_pkg::XLEN-1:0]   src2,
    output logic                      hazard
);

    // Entry 0 is the youngest write.
    logic [exu_pkg::REG_AW-1:0] entry_rd   [BYPASS_DEPTH];
    logic [exu_pkg::XLEN-1:0]   entry_data [BYPASS_DEPTH];
    logic [BYPASS_DEPTH-1:0]    entry_valid;
    logic [BYPASS_DEPTH-1:0]    entry_pend;

    logic [BYPASS_DEPTH-1:0]    fill_sel;      // One-hot, oldest pending entry.
    logic                       src1_wait;
    logic                       src2_wait;
    logic                       do_push;

    assign do_push = push && (push_rd != '0);

    // Oldest entry wins first, later hits are younger and override.
    always_comb begin
        src1      = in_src1_reg;
        src2      = in_src2_reg;
        src1_wait = 1'b0;
        src2_wait = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && (entry_rd[i] == in_rs1) && (in_rs1 != '0)) begin
                src1      = entry_data[i];
                src1_wait = entry_pend[i];
            end
            if (entry_valid[i] && (entry_rd[i] == in_rs2) && (in_rs2 != '0)) begin
                src2      = entry_data[i];
                src2_wait = entry_pend[i];
            end
        end
    end

    assign hazard = in_valid && (src1_wait || src2_wait);

    always_comb begin
        logic taken;
        taken    = 1'b0;
        fill_sel = '0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (!taken && load_done && entry_valid[i] && entry_pend[i]) begin
                fill_sel[i] = 1'b1;
                taken       = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_valid <= '0;
            entry_pend  <= '0;
        end else if (do_push) begin
            for (int i = BYPASS_DEPTH - 1; i > 0; i--) begin
                entry_valid[i] <= entry_valid[i-1];
                entry_pend[i]  <= entry_pend[i-1] && !fill_sel[i-1];
            end
            entry_valid[0] <= 1'b1;
            entry_pend[0]  <= push_is_load;
        end else begin
            entry_pend <= entry_pend & ~fill_sel;
        end
    end

    // Returned load data lands before the shift.
    always_ff @(posedge clk) begin
        if (do_push) begin
            for (int i = BYPASS_DEPTH - 1; i > 0; i--) begin
                entry_rd[i]   <= entry_rd[i-1];
                entry_data[i] <= fill_sel[i-1] ? load_data : entry_data[i-1];
            end
            entry_rd[0]   <= push_rd;
            entry_data[0] <= push_data;
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                if (fill_sel[i])
                    entry_data[i] <= load_data;
            end
        end
    end

endmodule

/* logic/alu.sv */
module alu (
    input  exu_pkg::alu_op_e        alu_op,
    input  exu_pkg::cmp_op_e        cmp_op,
    input  logic [exu_pkg::XLEN-1:0] pc,
    input  logic [exu_pkg::XLEN-1:0] imm,
    input  logic [exu_pkg::XLEN-1:0] src1,
    input  logic [exu_pkg::XLEN-1:0] src2,
    input  logic                    src1_is_pc,
    input  logic                    src2_is_imm,
    output logic [exu_pkg::XLEN-1:0] alu_result,
    output logic                    cmp_true
);

    logic [exu_pkg::XLEN-1:0] op_a;
    logic [exu_pkg::XLEN-1:0] op_b;
    logic [4:0]               shamt;
    logic                     src_eq;
    logic                     src_lt;
    logic                     src_ltu;

    assign op_a  = src1_is_pc  ? pc  : src1;
    assign op_b  = src2_is_imm ? imm : src2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            exu_pkg::alu_add:    alu_result = op_a + op_b;
            exu_pkg::alu_sub:    alu_result = op_a - op_b;
            exu_pkg::alu_sll:    alu_result = op_a << shamt;
            exu_pkg::alu_slt:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            exu_pkg::alu_sltu:   alu_result = {31'd0, op_a < op_b};
            exu_pkg::alu_xor:    alu_result = op_a ^ op_b;
            exu_pkg::alu_srl:    alu_result = op_a >> shamt;
            exu_pkg::alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
            exu_pkg::alu_or:     alu_result = op_a | op_b;
            exu_pkg::alu_and:    alu_result = op_a & op_b;
            exu_pkg::alu_pass_b: alu_result = op_b;
            default:             alu_result = '0;
        endcase
    end

    // Branch compare always looks at the register operands.
    assign src_eq  = (src1 == src2);
    assign src_lt  = ($signed(src1) < $signed(src2));
    assign src_ltu = (src1 < src2);

    always_comb begin
        case (cmp_op)
            exu_pkg::cmp_none:   cmp_true = 1'b0;
            exu_pkg::cmp_always: cmp_true = 1'b1;
            exu_pkg::cmp_eq:     cmp_true = src_eq;
            exu_pkg::cmp_ne:     cmp_true = !src_eq;
            exu_pkg::cmp_lt:     cmp_true = src_lt;
            exu_pkg::cmp_ge:     cmp_true = !src_lt;
            exu_pkg::cmp_ltu:    cmp_true = src_ltu;
            exu_pkg::cmp_geu:    cmp_true = !src_ltu;
            default:             cmp_true = 1'b0;
        endcase
    end

endmodule

/* common/exu_pkg.sv */
package exu_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 4;                  // RV32E, 16 registers.

    localparam int DEFAULT_BYPASS_DEPTH = 4;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10                      // Used by lui.
    } alu_op_e;

    // Branch condition, cmp_always marks jal and jalr.
    typedef enum logic [2:0] {
        cmp_none   = 3'd0,
        cmp_always = 3'd1,
        cmp_eq     = 3'd2,
        cmp_ne     = 3'd3,
        cmp_lt     = 3'd4,
        cmp_ge     = 3'd5,
        cmp_ltu    = 3'd6,
        cmp_geu    = 3'd7
    } cmp_op_e;

endpackage
